/* vlog.f */
+incdir+common
common/lc3b_pkg.sv
rtl/lc3b_regfile.sv
rtl/pipeline_barrier.sv
rtl/forwarding_controller.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/lc3b_pipeline.sv
dv/lc3b_pipeline_tb.sv

/* Bender.yml */
package:
  name: lc3b_pipeline

sources:
  - include_dirs:
      - common
    files:
      - common/lc3b_pkg.sv
      - rtl/lc3b_regfile.sv
      - rtl/pipeline_barrier.sv
      - rtl/forwarding_controller.sv
      - rtl/decode_stage.sv
      - rtl/execute_stage.sv
      - rtl/memory_stage.sv
      - rtl/lc3b_pipeline.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/lc3b_pipeline_tb.sv

/* dv/lc3b_pipeline_tb.sv */
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module lc3b_pipeline_tb;

    localparam int DIRECTED_INSTRS = 20;
    localparam int RANDOM_INSTRS   = 300;

    typedef struct {
        lc3b_pkg::lc3b_reg  dest;
        lc3b_pkg::lc3b_word data;
        string              name;
    } expected_write_t;

    logic               clk = 1'b0;
    logic               rst;
    logic               in_valid;
    lc3b_pkg::lc3b_word in_instr;
    logic               in_ready;
    logic               wb_valid;
    lc3b_pkg::lc3b_reg  wb_dest;
    lc3b_pkg::lc3b_word wb_data;

    // architectural state in program order
    lc3b_pkg::lc3b_word shadow_reg [8];
    lc3b_pkg::lc3b_word shadow_mem [`LC3B_DMEM_WORDS];
    expected_write_t    expected_q [$];
    string              test_name = "reset";

    // queue head as checked at the next rising edge
    logic               head_present;
    lc3b_pkg::lc3b_reg  head_dest;
    lc3b_pkg::lc3b_word head_data;
    string              head_name;

    // ID_EX occupant as implied by the handshake
    logic               occ_ldr;
    lc3b_pkg::lc3b_reg  occ_dest;
    logic               load_use;
    logic               first_accept;
    int                 accepted_count;

    always #20 clk = ~clk;

    lc3b_pipeline i_lc3b_pipeline (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .in_ready (in_ready),
        .wb_valid (wb_valid),
        .wb_dest  (wb_dest),
        .wb_data  (wb_data)
    );

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic lc3b_pkg::lc3b_word alu_imm_word(input lc3b_pkg::lc3b_opcode op,
            input lc3b_pkg::lc3b_reg d, input lc3b_pkg::lc3b_reg s, input logic [4:0] imm);
        return {op, d, s, 1'b1, imm};
    endfunction

    function automatic lc3b_pkg::lc3b_word alu_reg_word(input lc3b_pkg::lc3b_opcode op,
            input lc3b_pkg::lc3b_reg d, input lc3b_pkg::lc3b_reg s1, input lc3b_pkg::lc3b_reg s2);
        return {op, d, s1, 3'b000, s2};
    endfunction

    function automatic lc3b_pkg::lc3b_word not_word(input lc3b_pkg::lc3b_reg d,
            input lc3b_pkg::lc3b_reg s);
        return {lc3b_pkg::op_not, d, s, 6'b111111};
    endfunction

    function automatic lc3b_pkg::lc3b_word mem_word(input lc3b_pkg::lc3b_opcode op,
            input lc3b_pkg::lc3b_reg r, input lc3b_pkg::lc3b_reg base, input logic [5:0] off);
        return {op, r, base, off};
    endfunction

    // registers an instruction reads, from the ISA formats
    function automatic logic reads_reg(input lc3b_pkg::lc3b_word instr,
            input lc3b_pkg::lc3b_reg r);
        case (instr[15:12])
            lc3b_pkg::op_add, lc3b_pkg::op_and:
                return instr[8:6] == r || (!instr[5] && instr[2:0] == r);
            lc3b_pkg::op_not, lc3b_pkg::op_ldr: return instr[8:6] == r;
            lc3b_pkg::op_str: return instr[8:6] == r || instr[11:9] == r;
            default: return 1'b0;
        endcase
    endfunction

    function automatic void record_write(input lc3b_pkg::lc3b_reg d,
            input lc3b_pkg::lc3b_word value);
        shadow_reg[d] = value;
        expected_q.push_back('{dest: d, data: value, name: test_name});
    endfunction

    function automatic void apply_to_model(input lc3b_pkg::lc3b_word instr);
        lc3b_pkg::lc3b_word a;
        lc3b_pkg::lc3b_word b;
        lc3b_pkg::lc3b_word addr;
        int                 idx;
        a    = shadow_reg[instr[8:6]];
        b    = instr[5] ? {{11{instr[4]}}, instr[4:0]} : shadow_reg[instr[2:0]];
        // offset6 scaled by two, then taken as a word index
        addr = a + {{9{instr[5]}}, instr[5:0], 1'b0};
        idx  = addr % `LC3B_DMEM_WORDS;
        case (instr[15:12])
            lc3b_pkg::op_add: record_write(instr[11:9], a + b);
            lc3b_pkg::op_and: record_write(instr[11:9], a & b);
            lc3b_pkg::op_not: record_write(instr[11:9], ~a);
            lc3b_pkg::op_ldr: record_write(instr[11:9], shadow_mem[idx]);
            lc3b_pkg::op_str: shadow_mem[idx] = shadow_reg[instr[11:9]];
            default: ;
        endcase
    endfunction

    function automatic lc3b_pkg::lc3b_word random_instr();
        lc3b_pkg::lc3b_reg d;
        lc3b_pkg::lc3b_reg a;
        lc3b_pkg::lc3b_reg b;
        // four registers only, dense dependencies
        d = 3'($urandom_range(0, 3));
        a = 3'($urandom_range(0, 3));
        b = 3'($urandom_range(0, 3));
        case ($urandom_range(0, 8))
            0: return alu_reg_word(lc3b_pkg::op_add, d, a, b);
            1: return alu_imm_word(lc3b_pkg::op_add, d, a, 5'($urandom));
            2: return alu_reg_word(lc3b_pkg::op_and, d, a, b);
            3: return alu_imm_word(lc3b_pkg::op_and, d, a, 5'($urandom));
            4: return not_word(d, a);
            5, 6: return mem_word(lc3b_pkg::op_ldr, d, a, 6'($urandom));
            7: return mem_word(lc3b_pkg::op_str, d, a, 6'($urandom));
            // branch opcode, a no-op here
            default: return {4'b0000, 12'($urandom)};
        endcase
    endfunction

    // entered on a rising edge, returns on the accepting edge
    task automatic send_instr(input lc3b_pkg::lc3b_word instr);
        logic taken;
        taken = 1'b0;
        in_valid <= 1'b1;
        in_instr <= instr;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    // model updates half a cycle ahead of the edge they describe
    always @(negedge clk) begin
        if (rst) begin
            foreach (shadow_reg[i]) shadow_reg[i] = '0;
            foreach (shadow_mem[i]) shadow_mem[i] = '0;
            expected_q.delete();
            head_present   = 1'b0;
            occ_ldr        = 1'b0;
            occ_dest       = '0;
            load_use       = 1'b0;
            first_accept   = 1'b0;
            accepted_count = 0;
        end else begin
            // retire side first
            head_present = expected_q.size() != 0;
            if (head_present) begin
                head_dest = expected_q[0].dest;
                head_data = expected_q[0].data;
                head_name = expected_q[0].name;
                if (wb_valid) begin
                    void'(expected_q.pop_front());
                end
            end
            load_use     = 1'b0;
            first_accept = 1'b0;
            if (in_valid && in_ready) begin
                load_use       = occ_ldr && reads_reg(in_instr, occ_dest);
                occ_ldr        = in_instr[15:12] == lc3b_pkg::op_ldr;
                occ_dest       = in_instr[11:9];
                first_accept   = accepted_count == 0;
                accepted_count = accepted_count + 1;
                apply_to_model(in_instr);
            end else if (in_ready) begin
                occ_ldr = 1'b0;
            end
            // stalled, the consumer stays in ID_EX
        end
    end

    a_reset_state: assert property (@(posedge clk) rst |=> in_ready && !wb_valid)
        else stop_with_error("pipeline not idle right after a reset cycle");

    a_quiet_before_first: assert property (@(posedge clk) disable iff (rst)
        accepted_count == 0 |-> !wb_valid)
        else stop_with_error("trace fired before any instruction was accepted");

    a_first_write: assert property (@(posedge clk) disable iff (rst)
        first_accept |-> ##3 (wb_valid && wb_dest == 3'd1 && wb_data == 16'd5))
        else stop_with_error($sformatf("FAILED reset_first_add: expected r1=0005, actual %s",
            $sformatf("valid=%b r%0d=%h", $sampled(wb_valid), $sampled(wb_dest),
            $sampled(wb_data))));

    a_trace_order: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> head_present && wb_dest == head_dest && wb_data == head_data)
        else begin
            if (!head_present) begin
                stop_with_error("register write retired with no instruction expecting it");
            end else begin
                stop_with_error($sformatf("FAILED %s: expected r%0d=%h, actual r%0d=%h",
                    head_name, head_dest, head_data, $sampled(wb_dest), $sampled(wb_data)));
            end
        end

    a_load_use_stall: assert property (@(posedge clk) disable iff (rst)
        (in_valid && in_ready && load_use) |=>
            (!in_ready)[*`LC3B_LOAD_USE_BUBBLES] ##1 in_ready)
        else stop_with_error("load-use consumer did not see the expected in_ready bubble");

    a_no_extra_stall: assert property (@(posedge clk) disable iff (rst)
        !(in_valid && in_ready && load_use) |=> in_ready)
        else stop_with_error("in_ready dropped without a load-use hazard");

    // each instruction needs at most four cycles with gaps and a stall
    initial begin
        repeat ((DIRECTED_INSTRS + RANDOM_INSTRS) * 4 + 100) @(posedge clk);
        stop_with_error("watchdog expired before the program finished retiring");
    end

    initial begin
        void'($urandom(32'h685dd9d5));
        rst      = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        idle_cycles(3);

        test_name = "reset_first_add";
        send_instr(alu_imm_word(lc3b_pkg::op_add, 3'd1, 3'd0, 5'd5));
        idle_cycles(4);

        // distance 1, 2 and 3 producers
        test_name = "alu_forwarding";
        send_instr(alu_imm_word(lc3b_pkg::op_add, 3'd2, 3'd1, 5'd3));
        send_instr(alu_reg_word(lc3b_pkg::op_add, 3'd3, 3'd2, 3'd1));
        send_instr(alu_imm_word(lc3b_pkg::op_and, 3'd4, 3'd3, 5'd7));
        send_instr(not_word(3'd5, 3'd4));
        send_instr(alu_reg_word(lc3b_pkg::op_add, 3'd6, 3'd5, 3'd3));
        send_instr(alu_reg_word(lc3b_pkg::op_add, 3'd7, 3'd4, 3'd6));

        test_name = "load_use";
        send_instr(mem_word(lc3b_pkg::op_str, 3'd6, 3'd0, 6'd2));
        send_instr(mem_word(lc3b_pkg::op_ldr, 3'd2, 3'd0, 6'd2));
        send_instr(alu_imm_word(lc3b_pkg::op_add, 3'd3, 3'd2, 5'd1));
        send_instr(mem_word(lc3b_pkg::op_ldr, 3'd4, 3'd3, 6'd0));
        send_instr(not_word(3'd5, 3'd4));

        // forwarded store data, address wrap at both ends
        test_name = "store_load";
        send_instr(alu_imm_word(lc3b_pkg::op_add, 3'd1, 3'd0, 5'h1f));
        send_instr(mem_word(lc3b_pkg::op_str, 3'd1, 3'd1, 6'd1));
        send_instr(mem_word(lc3b_pkg::op_ldr, 3'd2, 3'd1, 6'd1));
        send_instr(alu_imm_word(lc3b_pkg::op_add, 3'd3, 3'd0, 5'd15));
        send_instr(mem_word(lc3b_pkg::op_str, 3'd3, 3'd0, 6'd31));
        send_instr(mem_word(lc3b_pkg::op_ldr, 3'd4, 3'd0, 6'h3f));
        send_instr(mem_word(lc3b_pkg::op_str, 3'd4, 3'd0, 6'd5));
        send_instr(mem_word(lc3b_pkg::op_ldr, 3'd5, 3'd0, 6'd5));

        test_name = "random_program";
        for (int i = 0; i < RANDOM_INSTRS; i++) begin
            send_instr(random_instr());
            if ($urandom_range(0, 3) == 0) begin
                idle_cycles($urandom_range(1, 2));
            end
        end

        // pipeline depth plus one bubble
        idle_cycles(6);
        if (expected_q.size() != 0) begin
            stop_with_error($sformatf("%0d expected register writes never retired",
                expected_q.size()));
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

/* rtl/lc3b_pipeline.sv */
`timescale 1ns/1ps

module lc3b_pipeline (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  lc3b_pkg::lc3b_word in_instr,
    output logic               in_ready,
    output logic               wb_valid,
    output lc3b_pkg::lc3b_reg  wb_dest,
    output lc3b_pkg::lc3b_word wb_data
);

    lc3b_pkg::lc3b_id_ex_t               id_ex_d;
    lc3b_pkg::lc3b_id_ex_t               id_ex_q;
    lc3b_pkg::lc3b_ex_mem_t              ex_mem_d;
    lc3b_pkg::lc3b_ex_mem_t              ex_mem_q;
    lc3b_pkg::lc3b_mem_wb_t              mem_wb_d;
    lc3b_pkg::lc3b_mem_wb_t              mem_wb_q;
    lc3b_pkg::lc3b_reg                   sr1_idx;
    lc3b_pkg::lc3b_reg                   sr2_idx;
    lc3b_pkg::lc3b_word                  sr1_data;
    lc3b_pkg::lc3b_word                  sr2_data;
    lc3b_pkg::lc3b_word                  mem_fwd_data;
    lc3b_pkg::lc3b_forward_mux_sel       forward_a_sel;
    lc3b_pkg::lc3b_forward_mux_sel       forward_b_sel;
    lc3b_pkg::lc3b_pipeline_control_word pipeline_control;

    // MEM_WB output is both the register write port and the trace
    assign wb_valid = mem_wb_q.valid & mem_wb_q.ctrl.regfile_load;
    assign wb_dest  = mem_wb_q.ctrl.regfile_dest;
    assign wb_data  = mem_wb_q.wb_data;

    decode_stage i_decode_stage (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .stall    (pipeline_control.barrier_if_id_stall),
        .held     (id_ex_q),
        .sr1_data (sr1_data),
        .sr2_data (sr2_data),
        .in_ready (in_ready),
        .sr1_idx  (sr1_idx),
        .sr2_idx  (sr2_idx),
        .id_ex    (id_ex_d)
    );

    lc3b_regfile i_lc3b_regfile (
        .clk    (clk),
        .rst    (rst),
        .we     (wb_valid),
        .waddr  (wb_dest),
        .wdata  (wb_data),
        .raddr1 (sr1_idx),
        .raddr2 (sr2_idx),
        .rdata1 (sr1_data),
        .rdata2 (sr2_data)
    );

    // ID_EX hold is done by the decode replay, which refreshes operands
    pipeline_barrier #(.payload_t(lc3b_pkg::lc3b_id_ex_t)) i_barrier_id_ex (
        .clk   (clk),
        .rst   (rst),
        .stall (1'b0),
        .clear (1'b0),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    forwarding_controller i_forwarding_controller (
        .id_ex_control            (id_ex_q.ctrl),
        .ex_mem_control           (ex_mem_q.ctrl),
        .mem_wb_control           (mem_wb_q.ctrl),
        .forward_a_sel            (forward_a_sel),
        .forward_b_sel            (forward_b_sel),
        .pipeline_control_request (pipeline_control)
    );

    execute_stage i_execute_stage (
        .id_ex         (id_ex_q),
        .forward_a_sel (forward_a_sel),
        .forward_b_sel (forward_b_sel),
        .mem_fwd_data  (mem_fwd_data),
        .wb_fwd_data   (mem_wb_q.wb_data),
        .ex_mem        (ex_mem_d)
    );

    // load-use bubble enters here
    pipeline_barrier #(.payload_t(lc3b_pkg::lc3b_ex_mem_t)) i_barrier_ex_mem (
        .clk   (clk),
        .rst   (rst),
        .stall (1'b0),
        .clear (pipeline_control.barrier_ex_mem_reset),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    memory_stage i_memory_stage (
        .clk          (clk),
        .rst          (rst),
        .ex_mem       (ex_mem_q),
        .mem_wb       (mem_wb_d),
        .mem_fwd_data (mem_fwd_data)
    );

    pipeline_barrier #(.payload_t(lc3b_pkg::lc3b_mem_wb_t)) i_barrier_mem_wb (
        .clk   (clk),
        .rst   (rst),
        .stall (1'b0),
        .clear (1'b0),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

endmodule

/* rtl/memory_stage.sv */
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module memory_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  lc3b_pkg::lc3b_ex_mem_t ex_mem,
    output lc3b_pkg::lc3b_mem_wb_t mem_wb,
    output lc3b_pkg::lc3b_word     mem_fwd_data
);

    localparam int ADDR_BITS = $clog2(`LC3B_DMEM_WORDS);

    lc3b_pkg::lc3b_word   dmem [`LC3B_DMEM_WORDS];
    logic [ADDR_BITS-1:0] index;
    logic                 store;
    logic                 load;
    lc3b_pkg::lc3b_word   wb_value;

    // byte address used as word index, wraps at memory depth
    assign index = ex_mem.alu_result[ADDR_BITS-1:0];
    assign store = ex_mem.valid & ex_mem.ctrl.data_memory_access &
                   ex_mem.ctrl.data_memory_write_enable;
    assign load  = ex_mem.valid & ex_mem.ctrl.data_memory_access &
                   ~ex_mem.ctrl.data_memory_write_enable;

    // write lands on the edge moving the store into MEM_WB
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LC3B_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (store) begin
            dmem[index] <= ex_mem.store_data;
        end
    end

    assign wb_value     = load ? dmem[index] : ex_mem.alu_result;
    assign mem_fwd_data = wb_value;

    always_comb begin
        mem_wb.valid   = ex_mem.valid;
        mem_wb.ctrl    = ex_mem.ctrl;
        mem_wb.wb_data = wb_value;
    end

    a_store_no_writeback: assert property (@(posedge clk) disable iff (rst)
        store |-> !ex_mem.ctrl.regfile_load)
        else $error("store decoded with a register write");

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  lc3b_pkg::lc3b_id_ex_t         id_ex,
    input  lc3b_pkg::lc3b_forward_mux_sel forward_a_sel,
    input  lc3b_pkg::lc3b_forward_mux_sel forward_b_sel,
    input  lc3b_pkg::lc3b_word            mem_fwd_data,
    input  lc3b_pkg::lc3b_word            wb_fwd_data,
    output lc3b_pkg::lc3b_ex_mem_t        ex_mem
);

    lc3b_pkg::lc3b_word operand_a;
    lc3b_pkg::lc3b_word operand_b;
    lc3b_pkg::lc3b_word alu_b;
    lc3b_pkg::lc3b_word alu_result;

    function automatic lc3b_pkg::lc3b_word forward_mux(
        input lc3b_pkg::lc3b_forward_mux_sel sel,
        input lc3b_pkg::lc3b_word            regfile_value
    );
        case (sel)
            lc3b_pkg::forward_mem_data: return mem_fwd_data;
            lc3b_pkg::forward_wb_data:  return wb_fwd_data;
            default:                    return regfile_value;
        endcase
    endfunction

    assign operand_a = forward_mux(forward_a_sel, id_ex.sr1_data);
    assign operand_b = forward_mux(forward_b_sel, id_ex.sr2_data);

    // immediate replaces sr2 for imm5 forms and address offsets
    assign alu_b = id_ex.ctrl.use_imm ? id_ex.ctrl.imm : operand_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            lc3b_pkg::alu_add: alu_result = operand_a + alu_b;
            lc3b_pkg::alu_and: alu_result = operand_a & alu_b;
            lc3b_pkg::alu_not: alu_result = ~operand_a;
            default:           alu_result = alu_b;
        endcase
    end

    always_comb begin
        ex_mem.valid      = id_ex.valid;
        ex_mem.ctrl       = id_ex.ctrl;
        ex_mem.alu_result = alu_result;
        // store data is sr2 after forwarding
        ex_mem.store_data = operand_b;
    end

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  lc3b_pkg::lc3b_word    in_instr,
    input  logic                  stall,
    input  lc3b_pkg::lc3b_id_ex_t held,
    input  lc3b_pkg::lc3b_word    sr1_data,
    input  lc3b_pkg::lc3b_word    sr2_data,
    output logic                  in_ready,
    output lc3b_pkg::lc3b_reg     sr1_idx,
    output lc3b_pkg::lc3b_reg     sr2_idx,
    output lc3b_pkg::lc3b_id_ex_t id_ex
);

    lc3b_pkg::lc3b_instr_u      instr;
    lc3b_pkg::lc3b_control_word cw;
    logic                       accept;

    assign instr    = in_instr;
    assign in_ready = ~stall;
    assign accept   = in_valid & in_ready;

    always_comb begin
        cw        = '0;
        cw.alu_op = lc3b_pkg::alu_pass;
        case (instr.alu_reg.opcode)
            lc3b_pkg::op_add, lc3b_pkg::op_and: begin
                cw.regfile_load = 1'b1;
                cw.regfile_dest = instr.alu_reg.dest;
                cw.regfile_sr1  = instr.alu_reg.sr1;
                cw.requires_sr1 = 1'b1;
                cw.alu_op       = (instr.alu_reg.opcode == lc3b_pkg::op_add) ?
                                  lc3b_pkg::alu_add : lc3b_pkg::alu_and;
                // steer bit picks imm5 over sr2
                if (instr.alu_imm.steer) begin
                    cw.use_imm = 1'b1;
                    cw.imm     = {{11{instr.alu_imm.imm5[4]}}, instr.alu_imm.imm5};
                end else begin
                    cw.regfile_sr2  = instr.alu_reg.sr2;
                    cw.requires_sr2 = 1'b1;
                end
            end
            lc3b_pkg::op_not: begin
                cw.regfile_load = 1'b1;
                cw.regfile_dest = instr.alu_reg.dest;
                cw.regfile_sr1  = instr.alu_reg.sr1;
                cw.requires_sr1 = 1'b1;
                cw.alu_op       = lc3b_pkg::alu_not;
            end
            lc3b_pkg::op_ldr, lc3b_pkg::op_str: begin
                // address is base plus offset6 scaled to bytes
                cw.regfile_sr1        = instr.mem.base;
                cw.requires_sr1       = 1'b1;
                cw.data_memory_access = 1'b1;
                cw.alu_op             = lc3b_pkg::alu_add;
                cw.use_imm            = 1'b1;
                cw.imm = {{9{instr.mem.offset6[5]}}, instr.mem.offset6, 1'b0};
                if (instr.mem.opcode == lc3b_pkg::op_str) begin
                    cw.data_memory_write_enable = 1'b1;
                    cw.regfile_sr2              = instr.mem.src_dest;
                    cw.requires_sr2             = 1'b1;
                end else begin
                    cw.regfile_load = 1'b1;
                    cw.regfile_dest = instr.mem.src_dest;
                end
            end
            default: begin
                cw.alu_op = lc3b_pkg::alu_pass;
            end
        endcase
        // a bubble clears all control
        if (!accept) begin
            cw = '0;
        end
    end

    // on a load-use stall the held instruction is replayed into ID_EX
    // with freshly read operands, so a write retiring during the stall is seen
    always_comb begin
        if (stall) begin
            sr1_idx = held.ctrl.regfile_sr1;
            sr2_idx = held.ctrl.regfile_sr2;
            id_ex   = held;
        end else begin
            sr1_idx     = cw.regfile_sr1;
            sr2_idx     = cw.regfile_sr2;
            id_ex.valid = accept;
            id_ex.ctrl  = cw;
        end
        id_ex.sr1_data = sr1_data;
        id_ex.sr2_data = sr2_data;
    end

    // a load-use stall lasts exactly the bubble count
    a_stall_length: assert property (@(posedge clk) disable iff (rst)
        $fell(in_ready) |-> (!in_ready)[*`LC3B_LOAD_USE_BUBBLES] ##1 in_ready)
        else $error("in_ready low outside a single load-use stall");

endmodule

/* rtl/forwarding_controller.sv */
`timescale 1ns/1ps

module forwarding_controller (
    input  lc3b_pkg::lc3b_control_word          id_ex_control,
    input  lc3b_pkg::lc3b_control_word          ex_mem_control,
    input  lc3b_pkg::lc3b_control_word          mem_wb_control,
    output lc3b_pkg::lc3b_forward_mux_sel       forward_a_sel,
    output lc3b_pkg::lc3b_forward_mux_sel       forward_b_sel,
    output lc3b_pkg::lc3b_pipeline_control_word pipeline_control_request
);

    logic ex_mem_to_ex_sr1;
    logic ex_mem_to_ex_sr2;
    logic mem_wb_to_ex_sr1;
    logic mem_wb_to_ex_sr2;
    logic ex_mem_is_load;

    always_comb begin
        // EX_MEM producer matches an EX source
        ex_mem_to_ex_sr1 = ex_mem_control.regfile_load & id_ex_control.requires_sr1 &
                           (id_ex_control.regfile_sr1 == ex_mem_control.regfile_dest);
        ex_mem_to_ex_sr2 = ex_mem_control.regfile_load & id_ex_control.requires_sr2 &
                           (id_ex_control.regfile_sr2 == ex_mem_control.regfile_dest);

        // MEM_WB producer matches
        mem_wb_to_ex_sr1 = mem_wb_control.regfile_load & id_ex_control.requires_sr1 &
                           (id_ex_control.regfile_sr1 == mem_wb_control.regfile_dest);
        mem_wb_to_ex_sr2 = mem_wb_control.regfile_load & id_ex_control.requires_sr2 &
                           (id_ex_control.regfile_sr2 == mem_wb_control.regfile_dest);

        // older producer first, younger one overrides
        forward_a_sel = lc3b_pkg::forward_pass;
        forward_b_sel = lc3b_pkg::forward_pass;
        if (mem_wb_to_ex_sr1) begin
            forward_a_sel = lc3b_pkg::forward_wb_data;
        end
        if (mem_wb_to_ex_sr2) begin
            forward_b_sel = lc3b_pkg::forward_wb_data;
        end
        if (ex_mem_to_ex_sr1) begin
            forward_a_sel = lc3b_pkg::forward_mem_data;
        end
        if (ex_mem_to_ex_sr2) begin
            forward_b_sel = lc3b_pkg::forward_mem_data;
        end

        // load data not ready for EX yet, hold the consumer one cycle
        ex_mem_is_load = ex_mem_control.data_memory_access &
                         ~ex_mem_control.data_memory_write_enable;
        pipeline_control_request = '0;
        if (ex_mem_is_load && (ex_mem_to_ex_sr1 || ex_mem_to_ex_sr2)) begin
            pipeline_control_request.active               = 1'b1;
            pipeline_control_request.barrier_if_id_stall  = 1'b1;
            pipeline_control_request.barrier_id_ex_stall  = 1'b1;
            pipeline_control_request.barrier_ex_mem_reset = 1'b1;
        end
    end

endmodule

/* rtl/pipeline_barrier.sv */
`timescale 1ns/1ps

module pipeline_barrier #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     clear,
    input  payload_t d,
    output payload_t q
);

    // cleared payload doubles as a bubble
    // valid and all control bits drop together
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

    a_stall_clear_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(stall && clear))
        else $error("barrier asked to hold and clear at once");

endmodule

/* rtl/lc3b_regfile.sv */
`timescale 1ns/1ps

module lc3b_regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic               we,
    input  lc3b_pkg::lc3b_reg  waddr,
    input  lc3b_pkg::lc3b_word wdata,
    input  lc3b_pkg::lc3b_reg  raddr1,
    input  lc3b_pkg::lc3b_reg  raddr2,
    output lc3b_pkg::lc3b_word rdata1,
    output lc3b_pkg::lc3b_word rdata2
);

    lc3b_pkg::lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // write-to-read bypass
    // an instruction three behind its producer decodes in the writeback cycle
    assign rdata1 = (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

/* common/lc3b_pkg.sv */
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;

    // executed opcodes, every other code decodes as a no-op
    typedef enum logic [3:0] {
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_not = 4'b1001,
        op_ldr = 4'b0110,
        op_str = 4'b0111
    } lc3b_opcode;

    // one instruction word, three ways to read it
    typedef union packed {
        struct packed {
            lc3b_opcode opcode;
            lc3b_reg    dest;
            lc3b_reg    sr1;
            logic       steer;
            logic [1:0] pad;
            lc3b_reg    sr2;
        } alu_reg;
        struct packed {
            lc3b_opcode opcode;
            lc3b_reg    dest;
            lc3b_reg    sr1;
            logic       steer;
            logic [4:0] imm5;
        } alu_imm;
        struct packed {
            lc3b_opcode opcode;
            lc3b_reg    src_dest;
            lc3b_reg    base;
            logic [5:0] offset6;
        } mem;
    } lc3b_instr_u;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_alu_op;

    typedef struct packed {
        logic       regfile_load;
        lc3b_reg    regfile_dest;
        lc3b_reg    regfile_sr1;
        lc3b_reg    regfile_sr2;
        logic       requires_sr1;
        logic       requires_sr2;
        logic       data_memory_access;
        logic       data_memory_write_enable;
        lc3b_alu_op alu_op;
        logic       use_imm;
        lc3b_word   imm;
    } lc3b_control_word;

    typedef enum logic [1:0] {
        forward_pass,
        forward_mem_data,
        forward_wb_data
    } lc3b_forward_mux_sel;

    typedef struct packed {
        logic active;
        logic barrier_if_id_stall;
        logic barrier_id_ex_stall;
        logic barrier_ex_mem_reset;
    } lc3b_pipeline_control_word;

    typedef struct packed {
        logic             valid;
        lc3b_control_word ctrl;
        lc3b_word         sr1_data;
        lc3b_word         sr2_data;
    } lc3b_id_ex_t;

    typedef struct packed {
        logic             valid;
        lc3b_control_word ctrl;
        lc3b_word         alu_result;
        lc3b_word         store_data;
    } lc3b_ex_mem_t;

    typedef struct packed {
        logic             valid;
        lc3b_control_word ctrl;
        lc3b_word         wb_data;
    } lc3b_mem_wb_t;

endpackage

/* common/lc3b_defines.svh */
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// data memory depth in 16-bit words
`define LC3B_DMEM_WORDS 64

// bubbles inserted between a load and its first consumer
`define LC3B_LOAD_USE_BUBBLES 1

`endif
